/* design/ppu_pkg.sv */
package ppu_pkg;

	typedef logic [2:0] reg_offset_t;
	typedef logic [13:0] vram_addr_t;
	typedef logic [4:0] pal_index_t;
	typedef logic [5:0] sys_color_t;
	typedef logic [3:0] rgb4_t;

	localparam reg_offset_t REG_CTRL = 3'd0;
	localparam reg_offset_t REG_MASK = 3'd1;
	localparam reg_offset_t REG_STATUS = 3'd2;
	localparam reg_offset_t REG_ADDR = 3'd6;
	localparam reg_offset_t REG_DATA = 3'd7;

	localparam vram_addr_t PALETTE_BASE = 14'h3F00;	// Palette window runs to 3FFF

	typedef union packed {
		logic [7:0] raw;	// As written by the CPU
		struct packed {
			logic nmi_enable;
			logic [1:0] ms_size;	// Master/slave and sprite size, not used here
			logic [1:0] pattern;	// Pattern table selects, not used here
			logic increment_32;
			logic [1:0] nt_select;
		} f;
	} ppu_ctrl_u;

	// Standard NES system palette, 8 bits per channel as R, G, B
	localparam logic [23:0] SYS_COLORS [64] = '{
		24'h545454, 24'h001E74, 24'h081090, 24'h300088,
		24'h440064, 24'h5C0030, 24'h540400, 24'h3C1800,
		24'h202A00, 24'h083A00, 24'h004000, 24'h003C00,
		24'h00323C, 24'h000000, 24'h000000, 24'h000000,
		24'h989698, 24'h084CC4, 24'h3032EC, 24'h5C1EE4,
		24'h8814B0, 24'hA01464, 24'h982220, 24'h783C00,
		24'h545A00, 24'h287200, 24'h087C00, 24'h007628,
		24'h006678, 24'h000000, 24'h000000, 24'h000000,
		24'hECEEEC, 24'h4C9AEC, 24'h787CEC, 24'hB062EC,
		24'hE454EC, 24'hEC58B4, 24'hEC6A64, 24'hD48820,
		24'hA0AA00, 24'h74C400, 24'h4CD020, 24'h38CC6C,
		24'h38B4CC, 24'h3C3C3C, 24'h000000, 24'h000000,
		24'hECEEEC, 24'hA8CCEC, 24'hBCBCEC, 24'hD4B2EC,
		24'hECAEEC, 24'hECAED4, 24'hECB4B0, 24'hE4C490,
		24'hCCD278, 24'hB4DE78, 24'hA8E290, 24'h98E2B4,
		24'hA0D6E4, 24'hA0A2A0, 24'h000000, 24'h000000
	};

	// Returns {r, g, b}, top nibble of each channel
	function automatic logic [11:0] sys_color_rgb4(input sys_color_t color);
		logic [23:0] full;
		full = SYS_COLORS[color];
		return {full[23:20], full[15:12], full[7:4]};
	endfunction

endpackage

/* design/palette_bus_if.sv */
`timescale 1ns/1ps

interface palette_bus_if;
	import ppu_pkg::*;

	pal_index_t index;
	sys_color_t wdata;
	logic we;
	logic re;	// Data-register read of the palette window
	sys_color_t rdata;

	modport regs (
		output index, wdata, we, re,
		input rdata
	);

	modport ram (
		input index, wdata, we, re,
		output rdata
	);

endinterface

/* design/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input logic vga_clk,
	input logic arst_n,
	output logic hs,
	output logic vs,
	output logic h_blank,
	output logic v_blank,
	output logic vblank_start
);

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int HW = $clog2(H_TOTAL);
	localparam int VW = $clog2(V_TOTAL);

	localparam logic [HW-1:0] H_LAST = HW'(H_TOTAL - 1);
	localparam logic [HW-1:0] H_BLANK_ON = HW'(H_ACTIVE);
	localparam logic [HW-1:0] H_SYNC_ON = HW'(H_ACTIVE + H_FRONT);
	localparam logic [HW-1:0] H_SYNC_OFF = HW'(H_ACTIVE + H_FRONT + H_SYNC);
	localparam logic [VW-1:0] V_LAST = VW'(V_TOTAL - 1);
	localparam logic [VW-1:0] V_BLANK_ON = VW'(V_ACTIVE);
	localparam logic [VW-1:0] V_SYNC_ON = VW'(V_ACTIVE + V_FRONT);
	localparam logic [VW-1:0] V_SYNC_OFF = VW'(V_ACTIVE + V_FRONT + V_SYNC);

	logic [HW-1:0] h_cnt;
	logic [VW-1:0] v_cnt;

	always_ff @(posedge vga_clk or negedge arst_n) begin
		if (!arst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == H_LAST) begin
			h_cnt <= '0;
			v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;	// Frame wrap
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	assign hs = !(h_cnt >= H_SYNC_ON && h_cnt < H_SYNC_OFF);	// Active low
	assign vs = !(v_cnt >= V_SYNC_ON && v_cnt < V_SYNC_OFF);
	assign h_blank = h_cnt >= H_BLANK_ON;
	assign v_blank = v_cnt >= V_BLANK_ON;
	assign vblank_start = (v_cnt == V_BLANK_ON) && (h_cnt == '0);

	a_cnt_range: assert property (@(posedge vga_clk) disable iff (!arst_n)
		h_cnt <= H_LAST && v_cnt <= V_LAST);

endmodule

/* design/ppu_cpu_regs.sv */
`timescale 1ns/1ps

module ppu_cpu_regs (
	input logic vga_clk,
	input logic arst_n,
	input ppu_pkg::reg_offset_t reg_addr,
	input logic [7:0] reg_din,
	input logic reg_wr,
	input logic reg_rd,
	input logic vblank_start,
	input logic v_blank,
	palette_bus_if.regs pal,
	output logic [7:0] reg_dout,
	output logic nmi,
	output logic grey
);
	import ppu_pkg::*;

	ppu_ctrl_u ctrl;
	logic [7:0] mask;
	logic w_latch;
	logic [5:0] addr_hi;	// First byte of the two-write address
	vram_addr_t vram_addr;
	logic [4:0] last_wr;	// Low bits of the last byte on the bus
	logic status_vbl;
	logic v_blank_q;

	logic in_pal;
	logic data_wr;
	logic data_rd;
	logic status_rd;
	logic v_blank_fall;

	assign in_pal = vram_addr >= PALETTE_BASE;
	assign data_wr = reg_wr && (reg_addr == REG_DATA);
	assign data_rd = reg_rd && (reg_addr == REG_DATA);
	assign status_rd = reg_rd && (reg_addr == REG_STATUS);
	assign v_blank_fall = v_blank_q && !v_blank;

	assign pal.index = vram_addr[4:0];
	assign pal.wdata = reg_din[5:0];
	assign pal.we = data_wr && in_pal;	// Outside the window, writes go nowhere
	assign pal.re = data_rd && in_pal;

	always_ff @(posedge vga_clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl <= '0;
			mask <= '0;
			w_latch <= 1'b0;
			addr_hi <= '0;
			vram_addr <= '0;
			last_wr <= '0;
		end else begin
			if (reg_wr) begin
				last_wr <= reg_din[4:0];
				case (reg_addr)
					REG_CTRL: ctrl.raw <= reg_din;
					REG_MASK: mask <= reg_din;
					REG_ADDR: begin
						if (!w_latch) begin
							addr_hi <= reg_din[5:0];
						end else begin
							vram_addr <= {addr_hi, reg_din};
						end
						w_latch <= !w_latch;
					end
					default: ;
				endcase
			end
			if (data_wr || data_rd) begin
				vram_addr <= vram_addr + (ctrl.f.increment_32 ? 14'd32 : 14'd1);
			end
			if (status_rd) begin
				w_latch <= 1'b0;
			end
		end
	end

	// Set wins over a status read landing on the same edge
	always_ff @(posedge vga_clk or negedge arst_n) begin
		if (!arst_n) begin
			status_vbl <= 1'b0;
			v_blank_q <= 1'b0;
		end else begin
			v_blank_q <= v_blank;
			if (vblank_start) begin
				status_vbl <= 1'b1;
			end else if (status_rd || v_blank_fall) begin
				status_vbl <= 1'b0;
			end
		end
	end

	always_ff @(posedge vga_clk or negedge arst_n) begin
		if (!arst_n) begin
			reg_dout <= '0;
		end else if (reg_rd) begin
			case (reg_addr)
				REG_STATUS: reg_dout <= {status_vbl, 2'b00, last_wr};
				REG_DATA: reg_dout <= in_pal ? {2'b00, pal.rdata} : 8'h00;	// No read buffer
				default: reg_dout <= 8'h00;
			endcase
		end
	end

	assign nmi = status_vbl && ctrl.f.nmi_enable;
	assign grey = mask[0];

	a_wr_rd_excl: assert property (@(posedge vga_clk) disable iff (!arst_n)
		!(reg_wr && reg_rd));

endmodule

/* design/palette_ram.sv */
`timescale 1ns/1ps

module palette_ram (
	input logic vga_clk,
	input logic arst_n,
	palette_bus_if.ram pal,
	output ppu_pkg::sys_color_t backdrop
);
	import ppu_pkg::*;

	sys_color_t mem [32];
	pal_index_t addr_f;

	// Sprite entries 0 of each group alias the background ones
	always_comb begin
		addr_f = pal.index;
		if (pal.index[1:0] == 2'b00) begin
			addr_f = {1'b0, pal.index[3:0]};
		end
	end

	always_ff @(posedge vga_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				mem[i] <= '0;
			end
		end else if (pal.we) begin
			mem[addr_f] <= pal.wdata;
		end
	end

	assign pal.rdata = mem[addr_f];
	assign backdrop = mem[0];	// Universal background colour

	a_we_re_excl: assert property (@(posedge vga_clk) disable iff (!arst_n)
		!(pal.we && pal.re));

endmodule

/* design/video_out.sv */
`timescale 1ns/1ps

module video_out (
	input logic vga_clk,
	input logic arst_n,
	input ppu_pkg::sys_color_t backdrop,
	input logic grey,
	input logic h_blank,
	input logic v_blank,
	output ppu_pkg::rgb4_t vga_r,
	output ppu_pkg::rgb4_t vga_g,
	output ppu_pkg::rgb4_t vga_b
);
	import ppu_pkg::*;

	sys_color_t color;
	logic [11:0] rgb;

	assign color = grey ? (backdrop & 6'h30) : backdrop;	// Greyscale keeps column 0
	assign rgb = sys_color_rgb4(color);

	always_ff @(posedge vga_clk or negedge arst_n) begin
		if (!arst_n) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else if (h_blank || v_blank) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else begin
			vga_r <= rgb[11:8];
			vga_g <= rgb[7:4];
			vga_b <= rgb[3:0];
		end
	end

endmodule

/* design/ppu_top.sv */
`timescale 1ns/1ps

module ppu_top #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input logic vga_clk,
	input logic arst_n,
	input ppu_pkg::reg_offset_t reg_addr,
	input logic [7:0] reg_din,
	input logic reg_wr,
	input logic reg_rd,
	output logic [7:0] reg_dout,
	output logic nmi,
	output ppu_pkg::rgb4_t vga_r,
	output ppu_pkg::rgb4_t vga_g,
	output ppu_pkg::rgb4_t vga_b,
	output logic vga_hs,
	output logic vga_vs
);
	import ppu_pkg::*;

	logic h_blank;
	logic v_blank;
	logic vblank_start;
	logic grey;
	sys_color_t backdrop;

	palette_bus_if pal_bus ();

	vga_timing #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) u_timing (
		.vga_clk(vga_clk),
		.arst_n(arst_n),
		.hs(vga_hs),
		.vs(vga_vs),
		.h_blank(h_blank),
		.v_blank(v_blank),
		.vblank_start(vblank_start)
	);

	ppu_cpu_regs u_regs (
		.vga_clk(vga_clk),
		.arst_n(arst_n),
		.reg_addr(reg_addr),
		.reg_din(reg_din),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.vblank_start(vblank_start),
		.v_blank(v_blank),
		.pal(pal_bus.regs),
		.reg_dout(reg_dout),
		.nmi(nmi),
		.grey(grey)
	);

	palette_ram u_palette (
		.vga_clk(vga_clk),
		.arst_n(arst_n),
		.pal(pal_bus.ram),
		.backdrop(backdrop)
	);

	video_out u_video (
		.vga_clk(vga_clk),
		.arst_n(arst_n),
		.backdrop(backdrop),
		.grey(grey),
		.h_blank(h_blank),
		.v_blank(v_blank),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

endmodule

/* test/ppu_checker.sv */
`timescale 1ns/1ps

module ppu_checker (
	input logic [7:0] reg_dout,
	input logic nmi,
	input logic [3:0] vga_r,
	input logic [3:0] vga_g,
	input logic [3:0] vga_b,
	input logic vga_hs,
	input logic vga_vs
);

	int test_errors = 0;	// Errors in the test that is running
	int tests_run = 0;
	int tests_failed = 0;
	logic [11:0] frame_color;
	int frame_hits;
	int frame_bad;
	int hs_low;
	int vs_low;

	task automatic compare(input string name, input string what,
			input logic [11:0] expected, input logic [11:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s %s expected %h actual %h", name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_read(input string name, input logic [7:0] expected);
		compare(name, "reg_dout", {4'h0, expected}, {4'h0, reg_dout});
	endtask

	task automatic check_nmi(input string name, input logic expected);
		compare(name, "nmi", {11'h000, expected}, {11'h000, nmi});
	endtask

	task automatic report_failure(input string name, input string msg);
		$display("%s: %s", name, msg);
		test_errors++;
	endtask

	task automatic frame_begin(input logic [11:0] color);
		frame_color = color;
		frame_hits = 0;
		frame_bad = 0;
		hs_low = 0;
		vs_low = 0;
	endtask

	// Each sample is either blank or the backdrop colour
	task automatic frame_sample(input string name);
		logic [11:0] rgb;
		rgb = {vga_r, vga_g, vga_b};
		if (vga_hs === 1'b0) begin
			hs_low++;
		end
		if (vga_vs === 1'b0) begin
			vs_low++;
		end
		if (rgb === frame_color) begin
			frame_hits++;
		end else if (rgb !== 12'h000) begin
			if (frame_bad == 0) begin
				$display("CHECK FAILED %s rgb expected %h actual %h", name, frame_color, rgb);
			end
			frame_bad++;
			test_errors++;
		end
	endtask

	task automatic frame_end(input string name, input int active_exp, input int hs_exp,
			input int vs_exp);
		if (frame_bad > 1) begin
			$display("%s: %0d pixels in the frame had a wrong colour", name, frame_bad);
		end
		compare(name, "backdrop pixels", 12'(active_exp), 12'(frame_hits));
		compare(name, "hsync low cycles", 12'(hs_exp), 12'(hs_low));
		compare(name, "vsync low cycles", 12'(vs_exp), 12'(vs_low));
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("PASS %s", name);
		end else begin
			$display("FAIL %s with %0d errors", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	task automatic print_counts();
		$display("%0d tests run, %0d passed, %0d failed",
			tests_run, tests_run - tests_failed, tests_failed);
	endtask

	function automatic bit any_failed();
		return (tests_failed != 0) || (test_errors != 0);
	endfunction

endmodule

/* test/tb_ppu_top.sv */
`timescale 1ns/1ps

module tb_ppu_top;
	import ppu_pkg::*;

	localparam int H_ACTIVE = 16;
	localparam int H_FRONT = 2;
	localparam int H_SYNC = 2;
	localparam int H_BACK = 2;
	localparam int V_ACTIVE = 8;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 1;
	localparam int V_BACK = 1;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam real CLK_PERIOD = 8.0;
	localparam string TRACE_FILE = "test/ppu_trace.txt";

	logic vga_clk;
	logic arst_n;
	logic [2:0] reg_addr;
	logic [7:0] reg_din;
	logic reg_wr;
	logic reg_rd;
	logic [7:0] reg_dout;
	logic nmi;
	logic [3:0] vga_r;
	logic [3:0] vga_g;
	logic [3:0] vga_b;
	logic vga_hs;
	logic vga_vs;

	string op_q[$];
	logic [2:0] off_q[$];
	logic [7:0] dat_q[$];
	logic [11:0] exp_q[$];
	string name_q[$];
	bit trace_ready = 1'b0;
	bit loaded;
	logic [31:0] lcg_state = 32'hb6e0;

	ppu_top #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) UUT (
		.vga_clk(vga_clk),
		.arst_n(arst_n),
		.reg_addr(reg_addr),
		.reg_din(reg_din),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.reg_dout(reg_dout),
		.nmi(nmi),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs)
	);

	ppu_checker chk (
		.reg_dout(reg_dout),
		.nmi(nmi),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs)
	);

	initial begin
		vga_clk = 1'b0;
		forever #(CLK_PERIOD / 2.0) vga_clk = ~vga_clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Entries 10h, 14h, 18h and 1Ch share storage with 00h, 04h, 08h and 0Ch
	function automatic logic [4:0] mirror_index(input logic [4:0] idx);
		if (idx >= 5'h10 && idx % 4 == 0) begin
			return idx - 5'h10;
		end
		return idx;
	endfunction

	task automatic load_trace(output bit ok);
		int fd;
		int fields;
		string line;
		string op;
		string name;
		logic [11:0] off;
		logic [11:0] dat;
		logic [11:0] expected;
		ok = 1'b0;
		fd = $fopen(TRACE_FILE, "r");
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				fields = $sscanf(line, "%s %h %h %h %s", op, off, dat, expected, name);
				if (fields == 5 && op.getc(0) != "#") begin
					op_q.push_back(op);
					off_q.push_back(off[2:0]);
					dat_q.push_back(dat[7:0]);
					exp_q.push_back(expected);
					name_q.push_back(name);
				end
			end
			$fclose(fd);
			ok = op_q.size() > 0;
		end
	endtask

	// Every task starts and ends 1 ns after a rising edge
	task automatic write_reg(input logic [2:0] offset, input logic [7:0] data);
		reg_addr = offset;
		reg_din = data;
		reg_wr = 1'b1;
		@(posedge vga_clk);
		#1;
		reg_wr = 1'b0;
	endtask

	task automatic read_expect(input string name, input logic [2:0] offset,
			input logic [7:0] expected);
		reg_addr = offset;
		reg_rd = 1'b1;
		@(posedge vga_clk);
		#1;
		reg_rd = 1'b0;
		chk.check_read(name, expected);
	endtask

	task automatic wait_vblank(input string name);
		logic vs_prev;
		bit seen;
		int n;
		vs_prev = vga_vs;
		seen = 1'b0;
		for (n = 0; n < 2 * FRAME_CYCLES && !seen; n++) begin
			@(posedge vga_clk);
			#1;
			seen = vs_prev && !vga_vs;	// Sync falls inside vertical blanking
			vs_prev = vga_vs;
		end
		if (!seen) begin
			chk.report_failure(name, "vertical sync never went low while waiting for vblank");
		end
	endtask

	task automatic frame_expect(input string name, input logic [11:0] color);
		chk.frame_begin(color);
		repeat (FRAME_CYCLES) begin
			@(posedge vga_clk);
			#1;
			chk.frame_sample(name);
		end
		chk.frame_end(name, H_ACTIVE * V_ACTIVE, H_SYNC * V_TOTAL, V_SYNC * H_TOTAL);
	endtask

	task automatic random_fill(input string name, input int count);
		logic [5:0] model [32];
		int i;
		for (i = 0; i < 32; i++) begin
			model[i] = '0;
		end
		write_reg(REG_ADDR, 8'h3F);
		write_reg(REG_ADDR, 8'h00);
		for (i = 0; i < count; i++) begin
			lcg_state = lcg_next(lcg_state);
			write_reg(REG_DATA, lcg_state[23:16]);	// Top two bits are dropped by the DUT
			model[mirror_index(i[4:0])] = lcg_state[21:16];
		end
		write_reg(REG_ADDR, 8'h3F);
		write_reg(REG_ADDR, 8'h00);
		for (i = 0; i < count; i++) begin
			read_expect(name, REG_DATA, {2'b00, model[mirror_index(i[4:0])]});
		end
	endtask

	task automatic run_trace();
		for (int i = 0; i < op_q.size(); i++) begin
			if (i > 0 && name_q[i] != name_q[i - 1]) begin
				chk.end_test(name_q[i - 1]);
			end
			case (op_q[i])
				"write": write_reg(off_q[i], dat_q[i]);
				"read": read_expect(name_q[i], off_q[i], exp_q[i][7:0]);
				"vblank": wait_vblank(name_q[i]);
				"nmi": chk.check_nmi(name_q[i], exp_q[i][0]);
				"frame": frame_expect(name_q[i], exp_q[i]);
				"fill": random_fill(name_q[i], int'(dat_q[i]));
				default: chk.report_failure(name_q[i], {"unknown trace operation ", op_q[i]});
			endcase
		end
		chk.end_test(name_q[op_q.size() - 1]);
	endtask

	// Two frames per trace line is far more than any line needs
	initial begin
		wait (trace_ready);
		#(real'(op_q.size()) * 2.0 * real'(FRAME_CYCLES) * CLK_PERIOD);
		$display("Watchdog expired before the trace finished, the simulation appears hung");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		reg_addr = '0;
		reg_din = '0;
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		load_trace(loaded);
		if (loaded) begin
			trace_ready = 1'b1;
			repeat (4) @(posedge vga_clk);
			#1;
			arst_n = 1'b1;
			run_trace();
			chk.print_counts();
		end else begin
			$display("Could not read any operation from %s", TRACE_FILE);
		end
		if (loaded && !chk.any_failed()) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* test/ppu_trace.txt */
# op offset data expect test, all numbers in hex
# frame expects 12-bit RGB, fill takes an entry count in the data column
write 6 3F 000 inc_by_1
write 6 01 000 inc_by_1
write 7 C5 000 inc_by_1
write 7 12 000 inc_by_1
write 7 7F 000 inc_by_1
write 6 3F 000 inc_by_1
write 6 01 000 inc_by_1
read 7 00 005 inc_by_1
read 7 00 012 inc_by_1
read 7 00 03F inc_by_1
write 0 04 000 inc_by_32
write 6 3F 000 inc_by_32
write 6 00 000 inc_by_32
write 7 15 000 inc_by_32
write 7 2A 000 inc_by_32
write 0 00 000 inc_by_32
write 6 3F 000 inc_by_32
write 6 00 000 inc_by_32
read 7 00 02A inc_by_32
read 7 00 005 inc_by_32
write 6 3F 000 mirror
write 6 10 000 mirror
write 7 19 000 mirror
write 6 3F 000 mirror
write 6 00 000 mirror
read 7 00 019 mirror
write 6 20 000 mirror
write 6 00 000 mirror
read 7 00 000 mirror
write 0 80 000 vblank_nmi
vblank 0 00 000 vblank_nmi
nmi 0 00 001 vblank_nmi
read 2 00 080 vblank_nmi
nmi 0 00 000 vblank_nmi
read 2 00 000 vblank_nmi
write 0 00 000 vblank_nmi
vblank 0 00 000 vblank_nmi
nmi 0 00 000 vblank_nmi
read 2 00 080 vblank_nmi
write 6 3F 000 backdrop
write 6 00 000 backdrop
write 7 21 000 backdrop
frame 0 21 49E backdrop
write 1 01 000 backdrop
frame 0 21 EEE backdrop
write 1 00 000 backdrop
fill 7 20 000 random_fill

/* ppu_top.f */
design/ppu_pkg.sv
design/palette_bus_if.sv
design/vga_timing.sv
design/ppu_cpu_regs.sv
design/palette_ram.sv
design/video_out.sv
design/ppu_top.sv
test/ppu_checker.sv
test/tb_ppu_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ppu_top -f ppu_top.f -Mdir obj_dir -o tb_ppu_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_ppu_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "ALL TESTS PASSED" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
